// ==== vlog.f ====
+incdir+verif
src/serdes_pkg.sv
src/lane_ctrl.sv
src/lane_serializer.sv
src/lane_deserializer.sv
src/serdes_top.sv
verif/tb_serdes.sv

// ==== Makefile ====
# Verilator simulation of the SerDes lane block

VERILATOR ?= verilator
TOP       ?= tb_serdes
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Result: PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verif/tb_serdes_tasks.svh ====
// Print the error, then stop the run
task automatic stop_on_error(input string why);
        if (why != "") begin
                $display("ERROR at %0d ns: %s", $time, why);
        end
        $display("Result: FAILED");
        $fatal(1, "stopped at the first error");
endtask

task automatic compare_dat(input string what, input dat_rx_word_t got, input dat_rx_word_t exp);
        if (got !== exp) begin
                $display("MISMATCH at %0d ns: %s got %h expected %h", $time, what, got, exp);
                stop_on_error("");
        end
endtask

task automatic compare_cmd(input string what, input cmd_rx_word_t got, input cmd_rx_word_t exp);
        if (got !== exp) begin
                $display("MISMATCH at %0d ns: %s got %h expected %h", $time, what, got, exp);
                stop_on_error("");
        end
endtask

task automatic compare_tri(input string what, input logic [LINE_NUM-1:0] got,
                           input logic [LINE_NUM-1:0] exp);
        if (got !== exp) begin
                $display("MISMATCH at %0d ns: %s got %h expected %h", $time, what, got, exp);
                stop_on_error("");
        end
endtask

// Transmit lines as {o_dat, o_cmd}
task automatic compare_lines(input string what, input logic [LINE_NUM-1:0] got,
                             input logic [LINE_NUM-1:0] exp);
        if (got !== exp) begin
                $display("MISMATCH at %0d ns: %s got %h expected %h", $time, what, got, exp);
                stop_on_error("");
        end
endtask

task automatic compare_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
                $display("MISMATCH at %0d ns: %s got %b expected %b", $time, what, got, exp);
                stop_on_error("");
        end
endtask

// Expected line bit that reads zero before the run
function automatic logic line_bit(input int c, input int b);
        if (c < 0) begin
                return 1'b0;
        end
        return exp_line[c][b];
endfunction

// Slice j is the bit n places before slice j of the period
task automatic check_rx();
        dat_rx_word_t ed;
        cmd_rx_word_t ec;
        int p;
        p = cyc - SER_FACTOR;
        for (int j = 0; j < SER_FACTOR; j++) begin
                for (int l = 0; l < DAT_IN; l++) begin
                        ed[j][l] = line_bit(p + j - slip_m[CMD_IN + l], CMD_OUT + l);
                end
                for (int l = 0; l < CMD_IN; l++) begin
                        ec[j][l] = line_bit(p + j - slip_m[l], l);
                end
        end
        compare_dat("o_rx_data", o_rx_data, ed);
        compare_cmd("o_rx_cmd", o_rx_cmd, ec);
endtask

// Sample just after the edge, then compare against the line model
task automatic advance_cycle();
        @(posedge i_clk);
        #1;
        cyc++;
        if (cyc >= MAX_CYC) begin
                stop_on_error("simulation ran past its cycle budget");
        end else if (i_rst_n) begin
                compare_lines("transmit lines", {o_dat, o_cmd}, exp_line[cyc]);
                compare_tri("o_tristate_int", o_tristate_int, exp_tri[cyc]);
                // Word period over one period ago
                if (cyc >= SER_FACTOR && exp_start[cyc - SER_FACTOR]) begin
                        compare_flag("o_rx_valid after a sent word", o_rx_valid, 1'b1);
                        words_seen++;
                end
                if (o_rx_valid) begin
                        check_rx();
                end
        end
endtask

task automatic idle_cycles(input int n);
        repeat (n) advance_cycle();
endtask

// Word accepted in this cycle reaches the lines one period later
task automatic record_word(input dat_tx_word_t d, input cmd_tx_word_t c,
                           input logic [LINE_NUM-1:0] t);
        int base;
        base = cyc + SER_FACTOR;
        if (base + SER_FACTOR >= MAX_CYC) begin
                stop_on_error("word accepted too close to the cycle budget");
        end else begin
                exp_start[base] = 1'b1;
                for (int s = 0; s < SER_FACTOR; s++) begin
                        exp_line[base + s] = {d[s], c[s]};
                        exp_tri[base + s]  = t;
                end
        end
endtask

task automatic random_word(output dat_tx_word_t d, output cmd_tx_word_t c,
                           output logic [LINE_NUM-1:0] t);
        d = dat_tx_word_t'(rand_bits($bits(dat_tx_word_t)));
        c = cmd_tx_word_t'(rand_bits($bits(cmd_tx_word_t)));
        t = LINE_NUM'(rand_bits(LINE_NUM));
endtask

// Four-phase handshake
// Lat counts the cycles from req to ack
task automatic send_word(input dat_tx_word_t d, input cmd_tx_word_t c,
                         input logic [LINE_NUM-1:0] t, output int lat);
        int n;
        i_tx_data  = d;
        i_tx_cmd   = c;
        i_tri_dval = t;
        i_tx_req   = 1'b1;
        lat = 0;
        while (!o_tx_ack && lat < ACK_TMO) begin
                advance_cycle();
                lat++;
        end
        if (!o_tx_ack) begin
                stop_on_error("timeout waiting for o_tx_ack to rise");
        end
        record_word(d, c, t);
        i_tx_req = 1'b0;
        n = 0;
        while (o_tx_ack && n < ACK_TMO) begin
                advance_cycle();
                n++;
        end
        if (o_tx_ack) begin
                stop_on_error("timeout waiting for o_tx_ack to fall");
        end
endtask

// Back to back words at one per period
task automatic send_stream(input int count);
        dat_tx_word_t d;
        cmd_tx_word_t c;
        logic [LINE_NUM-1:0] t;
        int lat;
        repeat (count) begin
                random_word(d, c, t);
                send_word(d, c, t, lat);
        end
endtask

task automatic wait_words(input int target);
        int n;
        n = 0;
        while (words_seen < target && n < 4 * SER_FACTOR) begin
                advance_cycle();
                n++;
        end
        if (words_seen < target) begin
                stop_on_error("sent words never came back on the receive side");
        end
endtask

task automatic pulse_bitslip(input int line);
        i_bitslip       = '0;
        i_bitslip[line] = 1'b1;
        advance_cycle();
        i_bitslip = '0;
        // Offset register moved at that edge
        slip_m[line] = (slip_m[line] + 1) % SER_FACTOR;
        advance_cycle();
endtask

task automatic test_after_reset();
        compare_flag("o_tx_ack after reset", o_tx_ack, 1'b0);
        compare_flag("o_rx_valid after reset", o_rx_valid, 1'b0);
        compare_tri("o_tristate_int after reset", o_tristate_int, '1);
        compare_lines("transmit lines after reset", {o_dat, o_cmd}, '0);
endtask

task automatic test_handshake();
        dat_tx_word_t d;
        cmd_tx_word_t c;
        logic [LINE_NUM-1:0] t;
        int lat;
        random_word(d, c, t);
        send_word(d, c, t, lat);
        compare_flag("acceptance within one word period", lat >= 1 && lat <= SER_FACTOR, 1'b1);
        // No second acceptance while the request stays low
        repeat (3 * SER_FACTOR) begin
                advance_cycle();
                compare_flag("o_tx_ack with i_tx_req low", o_tx_ack, 1'b0);
        end
endtask

task automatic test_loopback();
        int target;
        target = words_seen + 8;
        send_stream(8);
        wait_words(target);
endtask

// Words with idle periods between them
task automatic test_tristate();
        int target;
        target = words_seen + 3;
        repeat (3) begin
                send_stream(1);
                idle_cycles(2 * SER_FACTOR);
        end
        wait_words(target);
endtask

task automatic test_bitslip();
        int target;
        int cnt;
        for (int l = 0; l < CMD_IN; l++) begin
                cnt = 1 + int'(rand_bits(2)) % 3;
                repeat (cnt) pulse_bitslip(l);
        end
        idle_cycles(2 * SER_FACTOR);
        target = words_seen + 8;
        send_stream(8);
        wait_words(target);
endtask

// ==== verif/tb_serdes.sv ====
`timescale 1ns/1ps

module tb_serdes;
        import serdes_pkg::*;

        // Model arrays cover the whole run
        localparam int MAX_CYC = 2048;
        localparam int ACK_TMO = 4 * SER_FACTOR;
        // Galois feedback mask, x^32 + x^22 + x^2 + x + 1
        localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

        logic                 i_clk;
        logic                 i_rst_n;
        dat_tx_word_t         i_tx_data;
        cmd_tx_word_t         i_tx_cmd;
        logic [LINE_NUM-1:0]  i_tri_dval;
        logic                 i_tx_req;
        logic                 o_tx_ack;
        logic [DAT_OUT-1:0]   o_dat;
        logic [CMD_OUT-1:0]   o_cmd;
        logic [LINE_NUM-1:0]  o_tristate_int;
        logic [DAT_IN-1:0]    i_dat;
        logic [CMD_IN-1:0]    i_cmd;
        logic [DAT_IN+CMD_IN-1:0] i_bitslip;
        dat_rx_word_t         o_rx_data;
        cmd_rx_word_t         o_rx_cmd;
        logic                 o_rx_valid;

        // Cycle count since time zero
        int cyc;
        // Sent words that came back and were checked
        int words_seen;
        // Expected slip per receive line, command lines low
        int slip_m [DAT_IN+CMD_IN];
        // Expected line values and tristate per cycle, {data, command}
        logic [LINE_NUM-1:0] exp_line [MAX_CYC];
        logic [LINE_NUM-1:0] exp_tri [MAX_CYC];
        // First cycle of a period that carries a sent word
        logic exp_start [MAX_CYC];
        logic [31:0] lfsr_state;

        serdes_top dut_i (
                .i_clk          (i_clk),
                .i_rst_n        (i_rst_n),
                .i_tx_data      (i_tx_data),
                .i_tx_cmd       (i_tx_cmd),
                .i_tri_dval     (i_tri_dval),
                .i_tx_req       (i_tx_req),
                .o_tx_ack       (o_tx_ack),
                .o_dat          (o_dat),
                .o_cmd          (o_cmd),
                .o_tristate_int (o_tristate_int),
                .i_dat          (i_dat),
                .i_cmd          (i_cmd),
                .i_bitslip      (i_bitslip),
                .o_rx_data      (o_rx_data),
                .o_rx_cmd       (o_rx_cmd),
                .o_rx_valid     (o_rx_valid)
        );

        // Loopback, transmit lines straight into the receivers
        assign i_dat = o_dat[DAT_IN-1:0];
        assign i_cmd = o_cmd[CMD_IN-1:0];

        // 8 ns clock
        initial begin
                i_clk = 1'b0;
                forever #4 i_clk = ~i_clk;
        end

        // One LFSR step per bit
        function automatic logic rand_bit();
                logic out;
                out = lfsr_state[0];
                lfsr_state = lfsr_state >> 1;
                if (out) begin
                        lfsr_state = lfsr_state ^ LFSR_TAPS;
                end
                return out;
        endfunction

        // n random bits, right aligned
        function automatic logic [31:0] rand_bits(input int n);
                logic [31:0] r;
                r = '0;
                for (int i = 0; i < n; i++) begin
                        r = {r[30:0], rand_bit()};
                end
                return r;
        endfunction

        `include "tb_serdes_tasks.svh"

        initial begin
                lfsr_state = 32'd88;
                cyc        = 0;
                words_seen = 0;
                for (int l = 0; l < DAT_IN + CMD_IN; l++) begin
                        slip_m[l] = 0;
                end
                // Idle lines send zero and float
                for (int c = 0; c < MAX_CYC; c++) begin
                        exp_line[c]  = '0;
                        exp_tri[c]   = '1;
                        exp_start[c] = 1'b0;
                end
                i_rst_n    = 1'b0;
                i_tx_data  = '0;
                i_tx_cmd   = '0;
                i_tri_dval = '1;
                i_tx_req   = 1'b0;
                i_bitslip  = '0;
                repeat (16) advance_cycle();
                i_rst_n = 1'b1;
                test_after_reset();
                test_handshake();
                test_loopback();
                test_tristate();
                test_bitslip();
                $display("Result: PASSED");
                $finish;
        end

endmodule

// ==== src/serdes_top.sv ====
`timescale 1ns/1ps

module serdes_top #(
        parameter int SER_FACTOR = serdes_pkg::SER_FACTOR,
        parameter int DAT_OUT    = serdes_pkg::DAT_OUT,
        parameter int DAT_IN     = serdes_pkg::DAT_IN,
        parameter int CMD_OUT    = serdes_pkg::CMD_OUT,
        parameter int CMD_IN     = serdes_pkg::CMD_IN,
        parameter int LINE_NUM   = serdes_pkg::LINE_NUM
) (
        input  logic                     i_clk,
        input  logic                     i_rst_n,
        // Transmit words and their tristate mask
        input  serdes_pkg::dat_tx_word_t i_tx_data,
        input  serdes_pkg::cmd_tx_word_t i_tx_cmd,
        input  logic [LINE_NUM-1:0]      i_tri_dval,
        // Transmit handshake
        input  logic                     i_tx_req,
        output logic                     o_tx_ack,
        // Serial outputs
        output logic [DAT_OUT-1:0]       o_dat,
        output logic [CMD_OUT-1:0]       o_cmd,
        // Tristate per transmit line, command lines low
        output logic [LINE_NUM-1:0]      o_tristate_int,
        // Serial inputs
        input  logic [DAT_IN-1:0]        i_dat,
        input  logic [CMD_IN-1:0]        i_cmd,
        input  logic [DAT_IN+CMD_IN-1:0] i_bitslip,
        // Received words
        output serdes_pkg::dat_rx_word_t o_rx_data,
        output serdes_pkg::cmd_rx_word_t o_rx_cmd,
        output logic                     o_rx_valid
);
        import serdes_pkg::*;

        logic tx_load;
        logic rx_capture;
        slip_t [DAT_IN-1:0] slip_dat;
        slip_t [CMD_IN-1:0] slip_cmd;

        // Period timing, handshake and slip offsets
        lane_ctrl #(
                .SER_FACTOR (SER_FACTOR),
                .DAT_IN     (DAT_IN),
                .CMD_IN     (CMD_IN)
        ) lane_ctrl_i (
                .i_clk        (i_clk),
                .i_rst_n      (i_rst_n),
                .i_tx_req     (i_tx_req),
                .o_tx_ack     (o_tx_ack),
                .i_bitslip    (i_bitslip),
                .o_tx_load    (tx_load),
                .o_rx_capture (rx_capture),
                .o_rx_valid   (o_rx_valid),
                .o_slip_dat   (slip_dat),
                .o_slip_cmd   (slip_cmd)
        );

        // Data lines use the upper tristate bits
        lane_serializer #(
                .T_WORD     (dat_tx_word_t),
                .LANES      (DAT_OUT),
                .SER_FACTOR (SER_FACTOR)
        ) dat_ser_i (
                .i_clk   (i_clk),
                .i_rst_n (i_rst_n),
                .i_load  (tx_load),
                .i_word  (i_tx_data),
                .i_tri   (i_tri_dval[CMD_OUT +: DAT_OUT]),
                .o_line  (o_dat),
                .o_tri   (o_tristate_int[CMD_OUT +: DAT_OUT])
        );

        lane_serializer #(
                .T_WORD     (cmd_tx_word_t),
                .LANES      (CMD_OUT),
                .SER_FACTOR (SER_FACTOR)
        ) cmd_ser_i (
                .i_clk   (i_clk),
                .i_rst_n (i_rst_n),
                .i_load  (tx_load),
                .i_word  (i_tx_cmd),
                .i_tri   (i_tri_dval[CMD_OUT-1:0]),
                .o_line  (o_cmd),
                .o_tri   (o_tristate_int[CMD_OUT-1:0])
        );

        // Both receive groups share the capture strobe
        lane_deserializer #(
                .T_WORD     (dat_rx_word_t),
                .LANES      (DAT_IN),
                .SER_FACTOR (SER_FACTOR)
        ) dat_des_i (
                .i_clk     (i_clk),
                .i_rst_n   (i_rst_n),
                .i_line    (i_dat),
                .i_capture (rx_capture),
                .i_slip    (slip_dat),
                .o_word    (o_rx_data)
        );

        lane_deserializer #(
                .T_WORD     (cmd_rx_word_t),
                .LANES      (CMD_IN),
                .SER_FACTOR (SER_FACTOR)
        ) cmd_des_i (
                .i_clk     (i_clk),
                .i_rst_n   (i_rst_n),
                .i_line    (i_cmd),
                .i_capture (rx_capture),
                .i_slip    (slip_cmd),
                .o_word    (o_rx_cmd)
        );

endmodule

// ==== src/lane_deserializer.sv ====
`timescale 1ns/1ps

module lane_deserializer #(
        parameter type T_WORD     = serdes_pkg::dat_rx_word_t,
        parameter int  LANES      = serdes_pkg::DAT_IN,
        parameter int  SER_FACTOR = serdes_pkg::SER_FACTOR
) (
        input  logic                           i_clk,
        input  logic                           i_rst_n,
        // Serial lines, sampled every cycle
        input  logic [LANES-1:0]               i_line,
        // Last cycle of the word period
        input  logic                           i_capture,
        // Per line slip offset
        input  serdes_pkg::slip_t [LANES-1:0]  i_slip,
        // Parallel word, slice 0 on the right
        output T_WORD                          o_word
);

        // Current period plus the one before it
        localparam int HIST_W = 2 * SER_FACTOR;

        logic [LANES-1:0][HIST_W-1:0] hist;
        logic [LANES-1:0][HIST_W-1:0] hist_nxt;
        logic [SER_FACTOR-1:0][LANES-1:0] word_nxt;

        // Newest bit enters at the top
        // Older bits drift toward index 0
        always_comb begin
                for (int l = 0; l < LANES; l++) begin
                        hist_nxt[l] = {i_line[l], hist[l][HIST_W-1:1]};
                end
        end

        always_ff @(posedge i_clk) begin
                if (!i_rst_n) begin
                        hist <= '0;
                end else begin
                        hist <= hist_nxt;
                end
        end

        // Window selection per line
        // With zero slip slice j sits at SER_FACTOR+j
        // Each slip step reaches one bit further back
        always_comb begin
                for (int l = 0; l < LANES; l++) begin
                        for (int j = 0; j < SER_FACTOR; j++) begin
                                word_nxt[j][l] = hist_nxt[l][SER_FACTOR + j - int'(i_slip[l])];
                        end
                end
        end

        // Window taken with the bit arriving in the capture cycle
        // Held until the next period ends
        always_ff @(posedge i_clk) begin
                if (i_capture) begin
                        o_word <= word_nxt;
                end
        end

        // Offsets from the control block stay inside one word
        for (genvar l = 0; l < LANES; l++) begin : g_slip_chk
                a_slip_range: assert property (@(posedge i_clk) disable iff (!i_rst_n)
                        int'(i_slip[l]) < SER_FACTOR);
        end

endmodule

// ==== src/lane_serializer.sv ====
`timescale 1ns/1ps

module lane_serializer #(
        parameter type T_WORD     = serdes_pkg::dat_tx_word_t,
        parameter int  LANES      = serdes_pkg::DAT_OUT,
        parameter int  SER_FACTOR = serdes_pkg::SER_FACTOR
) (
        input  logic             i_clk,
        input  logic             i_rst_n,
        // Boundary strobe with an accepted word
        input  logic             i_load,
        input  T_WORD            i_word,
        // Tristate mask for the word, 1 is high impedance
        input  logic [LANES-1:0] i_tri,
        // Serial lines and their tristate controls
        output logic [LANES-1:0] o_line,
        output logic [LANES-1:0] o_tri
);

        localparam int WORD_W = SER_FACTOR * LANES;
        // Two words deep
        // Upper half waits out one period, lower half is on the lines
        localparam int PIPE_W = 2 * WORD_W;

        logic [PIPE_W-1:0] word_sr;
        logic [PIPE_W-1:0] tri_sr;
        logic [PIPE_W-1:0] word_sr_nxt;
        logic [PIPE_W-1:0] tri_sr_nxt;

        // One slice per cycle toward the lines
        // A load drops the new word into the upper half
        // Upper half is always empty at a boundary
        always_comb begin
                if (i_load) begin
                        word_sr_nxt = {i_word, word_sr[LANES +: WORD_W]};
                        // Mask repeated for every slice of the period
                        tri_sr_nxt  = {{SER_FACTOR{i_tri}}, tri_sr[LANES +: WORD_W]};
                end else begin
                        // Idle fill sends zero
                        word_sr_nxt = {{LANES{1'b0}}, word_sr[PIPE_W-1:LANES]};
                        // Idle fill floats the lines
                        tri_sr_nxt  = {{LANES{1'b1}}, tri_sr[PIPE_W-1:LANES]};
                end
        end

        always_ff @(posedge i_clk) begin
                if (!i_rst_n) begin
                        word_sr <= '0;
                        tri_sr  <= '1;
                end else begin
                        word_sr <= word_sr_nxt;
                        tri_sr  <= tri_sr_nxt;
                end
        end

        // Lines come straight from register bits
        // Slice 0 of a word shows in phase 0 of its period
        assign o_line = word_sr[LANES-1:0];
        assign o_tri  = tri_sr[LANES-1:0];

endmodule

// ==== src/lane_ctrl.sv ====
`timescale 1ns/1ps

module lane_ctrl #(
        parameter int SER_FACTOR = serdes_pkg::SER_FACTOR,
        parameter int DAT_IN     = serdes_pkg::DAT_IN,
        parameter int CMD_IN     = serdes_pkg::CMD_IN
) (
        input  logic                                i_clk,
        input  logic                                i_rst_n,
        // Four-phase transmit handshake
        input  logic                                i_tx_req,
        output logic                                o_tx_ack,
        // One bit per receive line, command lines low
        input  logic [DAT_IN+CMD_IN-1:0]            i_bitslip,
        // Word period strobes
        output logic                                o_tx_load,
        output logic                                o_rx_capture,
        output logic                                o_rx_valid,
        // Slip offsets per receive line
        output serdes_pkg::slip_t [DAT_IN-1:0]      o_slip_dat,
        output serdes_pkg::slip_t [CMD_IN-1:0]      o_slip_cmd
);
        import serdes_pkg::*;

        localparam int PH_W = (SER_FACTOR > 1) ? $clog2(SER_FACTOR) : 1;
        localparam logic [PH_W-1:0] PH_LAST = PH_W'(SER_FACTOR - 1);
        localparam slip_t SLIP_LAST = slip_t'(SER_FACTOR - 1);

        typedef enum logic {
                ST_IDLE,
                ST_ACK
        } ack_state_t;

        ack_state_t state;
        logic [PH_W-1:0] phase;
        logic boundary;

        // Offset wraps back to zero after the last slice
        function automatic slip_t next_slip(input slip_t cur);
                if (cur == SLIP_LAST) begin
                        return '0;
                end
                return cur + slip_t'(1);
        endfunction

        // Phase counter replaces the divided clock
        always_ff @(posedge i_clk) begin
                if (!i_rst_n) begin
                        phase <= '0;
                end else if (phase == PH_LAST) begin
                        phase <= '0;
                end else begin
                        phase <= phase + 1'b1;
                end
        end

        // Last cycle of the period
        assign boundary = (phase == PH_LAST);

        // Accept only from idle, so one word per request
        assign o_tx_load = boundary && i_tx_req && (state == ST_IDLE);

        // Receive side never stalls
        assign o_rx_capture = boundary;

        // Ack FSM
        // Ack stays up until the request is seen low
        always_ff @(posedge i_clk) begin
                if (!i_rst_n) begin
                        state <= ST_IDLE;
                end else begin
                        case (state)
                                ST_IDLE: begin
                                        if (o_tx_load) begin
                                                state <= ST_ACK;
                                        end
                                end
                                ST_ACK: begin
                                        if (!i_tx_req) begin
                                                state <= ST_IDLE;
                                        end
                                end
                                default: begin
                                        state <= ST_IDLE;
                                end
                        endcase
                end
        end

        assign o_tx_ack = (state == ST_ACK);

        // Word is out of the deserializers one cycle after capture
        always_ff @(posedge i_clk) begin
                if (!i_rst_n) begin
                        o_rx_valid <= 1'b0;
                end else begin
                        o_rx_valid <= o_rx_capture;
                end
        end

        // Each bitslip cycle moves that line one slice
        always_ff @(posedge i_clk) begin
                if (!i_rst_n) begin
                        o_slip_dat <= '0;
                        o_slip_cmd <= '0;
                end else begin
                        for (int l = 0; l < CMD_IN; l++) begin
                                if (i_bitslip[l]) begin
                                        o_slip_cmd[l] <= next_slip(o_slip_cmd[l]);
                                end
                        end
                        for (int l = 0; l < DAT_IN; l++) begin
                                if (i_bitslip[CMD_IN + l]) begin
                                        o_slip_dat[l] <= next_slip(o_slip_dat[l]);
                                end
                        end
                end
        end

        // Ack answers a request that was live when the word was taken
        a_ack_needs_req: assert property (@(posedge i_clk) disable iff (!i_rst_n)
                $rose(o_tx_ack) |-> $past(i_tx_req));

        // Load lands on a boundary, next cycle opens a period with ack up
        a_load_at_boundary: assert property (@(posedge i_clk) disable iff (!i_rst_n)
                o_tx_load |=> (o_rx_valid && o_tx_ack));

endmodule

// ==== src/serdes_pkg.sv ====
package serdes_pkg;

        // Slices per parallel word
        localparam int SER_FACTOR = 4;

        // Transmit line counts
        localparam int DAT_OUT = 8;
        localparam int CMD_OUT = 2;

        // Receive line counts
        localparam int DAT_IN = 1;
        localparam int CMD_IN = 2;

        // All transmit lines, command lines in the low bits
        localparam int LINE_NUM = DAT_OUT + CMD_OUT;

        // Parallel words, slice 0 is the earliest in time and sits on the right
        typedef logic [SER_FACTOR-1:0][DAT_OUT-1:0] dat_tx_word_t;
        typedef logic [SER_FACTOR-1:0][CMD_OUT-1:0] cmd_tx_word_t;

        // Receive side words, same slice order
        typedef logic [SER_FACTOR-1:0][DAT_IN-1:0] dat_rx_word_t;
        typedef logic [SER_FACTOR-1:0][CMD_IN-1:0] cmd_rx_word_t;

        // Per line bitslip offset
        // Legal values 0 to SER_FACTOR-1
        typedef logic [$clog2(SER_FACTOR)-1:0] slip_t;

endpackage
